// ==== common/disp_settings.svh ====
`ifndef DISP_SETTINGS_SVH
`define DISP_SETTINGS_SVH

// Display chain geometry
`define DISP_DIGITS 8            // Seven-segment digits on the chain
`define SEG_FRAME_BITS 64        // One byte per digit
`define LED_FRAME_BITS 16        // Discrete LEDs behind second chip chain

// Chips take the first bit out as the far end of the chain
`define SHIFT_MSB_FIRST 1

`endif

// ==== common/disp_types_pkg.sv ====
package disp_types_pkg;

	`include "disp_settings.svh"

	////////////////////////////////////////////////////////////////////
	// Payload types of the display path
	////////////////////////////////////////////////////////////////////

	// One hex nibble
	typedef logic [3:0] hex_digit_t;

	// Segment byte, bit 0 is segment a up to bit 6 segment g
	// Bit 7 is the decimal point, all active high
	typedef logic [7:0] seg_byte_t;

	// Eight nibbles, digit 7 in the top nibble
	typedef logic [4*`DISP_DIGITS-1:0] hex_word_t;

	typedef logic [`SEG_FRAME_BITS-1:0] seg_frame_t;  // Digit 7 in top byte
	typedef logic [`LED_FRAME_BITS-1:0] led_frame_t;  // One bit per LED

endpackage

// ==== common/disp_ctrl_pkg.sv ====
package disp_ctrl_pkg;

	////////////////////////////////////////////////////////////////////
	// Control encodings
	////////////////////////////////////////////////////////////////////

	// Frame sequencer
	typedef enum logic [2:0] {
		IDLE,       // Waiting for update
		SEG_START,  // Kick segment serializer
		SEG_WAIT,   // Segment frame on the wire
		LED_START,  // Kick LED serializer
		LED_WAIT    // LED frame on the wire
	} disp_state_t;

	// Shift register mode, laid out like the S1/S0 pins of a 194-type part
	typedef enum logic [1:0] {
		HOLD = 2'b00,
		SHR  = 2'b01,  // Fill enters top bit
		SHL  = 2'b10,  // Fill enters bit 0
		LOAD = 2'b11
	} shift_mode_t;

endpackage

// ==== common/shift_port_if.sv ====
`timescale 1ns/1ps

interface shift_port_if import disp_ctrl_pkg::*; #(
	parameter int WIDTH = 9     // Data bits plus guard bit
) ();

	shift_mode_t      mode;     // Operation for the next edge
	logic [WIDTH-1:0] d;        // Parallel load value
	logic [WIDTH-1:0] q;        // Register contents
	logic             fill;     // Bit entering the vacated end

	// Serializer side
	modport ctrl (
		output mode, d, fill,
		input  q
	);

	// Register side
	modport sreg (
		input  mode, d, fill,
		output q
	);

endinterface

// ==== serializer/universal_shifter.sv ====
`timescale 1ns/1ps

module universal_shifter import disp_ctrl_pkg::*; #(
	parameter int WIDTH = 9
) (
	input logic          clk,
	input logic          reset,
	shift_port_if.sreg   port
);

	//////////////////////////////////////////////////////////////////////
	// Four-mode register
	//////////////////////////////////////////////////////////////////////

	// All ones after reset
	// The serializer reads that as a finished frame, so the chain stays idle
	always_ff @(posedge clk) begin
		if (reset) begin
			port.q <= '1;
		end else begin
			case (port.mode)
				HOLD: port.q <= port.q;
				SHL:  port.q <= {port.q[WIDTH-2:0], port.fill};  // Toward MSB
				SHR:  port.q <= {port.fill, port.q[WIDTH-1:1]};  // Toward LSB
				LOAD: port.q <= port.d;
				default: port.q <= port.q;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	// Mode comes from the serializer in another module
	// An X here would smear the whole frame
	a_mode_known: assert property (
		@(posedge clk) disable iff (reset)
		!$isunknown(port.mode)
	) else $error("universal_shifter: mode unknown");

endmodule

// ==== serializer/p2s_serializer.sv ====
`timescale 1ns/1ps

`include "disp_settings.svh"

module p2s_serializer import disp_ctrl_pkg::*; #(
	parameter int DATA_BITS = 64,
	parameter bit MSB_FIRST = `SHIFT_MSB_FIRST
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 start,      // One-cycle kick
	input  logic [DATA_BITS-1:0] pdata,      // Frame to send
	output logic                 sout,       // Serial data to chip chain
	output logic                 sclk,       // Shift clock, rises mid-bit
	output logic                 latch,      // Storage register strobe
	output logic                 done,       // Cycle after latch
	shift_port_if.ctrl           sp
);

	logic load_pend;   // Start seen, load on this cycle
	logic phase;       // 0 presents the bit, 1 clocks it
	logic finish;      // All bits except the guard are ones
	logic finish_d;    // Finish one cycle ago
	logic q_out;       // Bit at the outgoing end

	//////////////////////////////////////////////////////////////////////
	// Guard bit and finish decode
	//////////////////////////////////////////////////////////////////////

	// Zero guard sits at the trailing end
	// Ones fill in behind the data, and the frame is over once only
	// the guard is left at the outgoing end
	assign sp.d    = MSB_FIRST ? {pdata, 1'b0} : {1'b0, pdata};
	assign sp.fill = 1'b1;
	assign finish  = MSB_FIRST ? &sp.q[DATA_BITS-1:0] : &sp.q[DATA_BITS:1];
	assign q_out   = MSB_FIRST ? sp.q[DATA_BITS] : sp.q[0];

	// Idle line sits low, and the guard itself never goes out
	assign sout = finish ? 1'b0 : q_out;

	//////////////////////////////////////////////////////////////////////
	// Bit rhythm
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			load_pend <= 1'b0;
			phase     <= 1'b0;
			finish_d  <= 1'b1;  // Matches the all-ones register after reset
			done      <= 1'b0;
		end else begin
			load_pend <= start;
			phase     <= finish ? 1'b0 : ~phase;  // Two cycles per bit
			finish_d  <= finish;
			done      <= latch;
		end
	end

	assign sclk = phase;  // Registered, high in second half of each bit

	// Shift at the end of the high half
	always_comb begin
		if (load_pend) begin
			sp.mode = LOAD;
		end else if (!finish && phase) begin
			sp.mode = MSB_FIRST ? SHL : SHR;
		end else begin
			sp.mode = HOLD;
		end
	end

	// Single pulse when the last data bit has left
	assign latch = finish & ~finish_d;

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	// Chips must see a stable storage strobe with the shift clock parked
	a_latch_sclk: assert property (
		@(posedge clk) disable iff (reset)
		!(latch && sclk)
	) else $error("p2s_serializer: latch with sclk high");

	// Controller owns the pacing
	a_start_idle: assert property (
		@(posedge clk) disable iff (reset)
		start |-> !(load_pend || !finish || latch)
	) else $error("p2s_serializer: start during frame");

endmodule

// ==== hdl/seg_encoder.sv ====
`timescale 1ns/1ps

`include "disp_settings.svh"

module seg_encoder import disp_types_pkg::*; (
	input  hex_word_t               hex_value,  // Digit 7 in top nibble
	input  logic [`DISP_DIGITS-1:0] dot_mask,   // One dot per digit
	output seg_frame_t              frame       // Digit 7 in top byte
);

	//////////////////////////////////////////////////////////////////////
	// Segment table
	//////////////////////////////////////////////////////////////////////

	//     a
	//   f   b
	//     g
	//   e   c
	//     d
	function automatic seg_byte_t hex_to_seg(input hex_digit_t digit);
		seg_byte_t seg;
		case (digit)
			4'h0: seg = 8'h3F;
			4'h1: seg = 8'h06;
			4'h2: seg = 8'h5B;
			4'h3: seg = 8'h4F;
			4'h4: seg = 8'h66;
			4'h5: seg = 8'h6D;
			4'h6: seg = 8'h7D;
			4'h7: seg = 8'h07;
			4'h8: seg = 8'h7F;
			4'h9: seg = 8'h6F;
			4'hA: seg = 8'h77;
			4'hB: seg = 8'h7C;  // Lower case b
			4'hC: seg = 8'h39;
			4'hD: seg = 8'h5E;  // Lower case d
			4'hE: seg = 8'h79;
			4'hF: seg = 8'h71;
			default: seg = 8'h00;
		endcase
		return seg;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Frame assembly
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		seg_byte_t seg;
		frame = '0;
		for (int i = 0; i < `DISP_DIGITS; i++) begin
			seg = hex_to_seg(hex_value[i*4 +: 4]);
			seg[7] = dot_mask[i];           // Dot overrides table bit
			frame[i*8 +: 8] = seg;          // Digit i into byte i
		end
	end

endmodule

// ==== hdl/display_ctrl.sv ====
`timescale 1ns/1ps

module display_ctrl import disp_ctrl_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic update,     // Request from outside
	input  logic seg_done,   // Segment serializer finished
	input  logic led_done,   // LED serializer finished
	output logic seg_start,
	output logic led_start,
	output logic capture,    // Load enable for the input registers
	output logic busy
);

	disp_state_t state;
	disp_state_t state_nxt;

	//////////////////////////////////////////////////////////////////////
	// Sequencer
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (update) begin
					state_nxt = SEG_START;
				end
			end
			SEG_START: state_nxt = SEG_WAIT;  // Single start cycle
			SEG_WAIT: begin
				if (seg_done) begin
					state_nxt = LED_START;
				end
			end
			LED_START: state_nxt = LED_WAIT;
			LED_WAIT: begin
				if (led_done) begin
					state_nxt = IDLE;     // Busy drops next cycle
				end
			end
			default: state_nxt = IDLE;
		endcase
	end

	// Outputs decoded from state
	assign capture   = (state == IDLE) && update;  // Updates while busy fall through
	assign seg_start = (state == SEG_START);
	assign led_start = (state == LED_START);
	assign busy      = (state != IDLE);

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	a_one_start: assert property (
		@(posedge clk) disable iff (reset)
		!(seg_start && led_start)
	) else $error("display_ctrl: both starts high");

endmodule

// ==== hdl/serial_display_top.sv ====
`timescale 1ns/1ps

`include "disp_settings.svh"

module serial_display_top import disp_types_pkg::*; (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    update,       // Single-cycle strobe
	input  hex_word_t               hex_value,
	input  logic [`DISP_DIGITS-1:0] dot_mask,
	input  led_frame_t              led_pattern,
	output logic                    busy,
	output logic                    seg_sout,
	output logic                    seg_sclk,
	output logic                    seg_latch,
	output logic                    led_sout,
	output logic                    led_sclk,
	output logic                    led_latch
);

	logic                    capture;
	logic                    seg_start;
	logic                    seg_done;
	logic                    led_start;
	logic                    led_done;
	hex_word_t               hex_q;     // Value held for the transfer
	logic [`DISP_DIGITS-1:0] dot_q;
	led_frame_t              led_q;
	seg_frame_t              seg_frame;

	// Payload only, loaded once per update
	always_ff @(posedge clk) begin
		if (capture) begin
			hex_q <= hex_value;
			dot_q <= dot_mask;
			led_q <= led_pattern;
		end
	end

	display_ctrl u_ctrl (
		.clk(clk), .reset(reset), .update(update),
		.seg_done(seg_done), .led_done(led_done),
		.seg_start(seg_start), .led_start(led_start),
		.capture(capture), .busy(busy)
	);

	seg_encoder u_enc (.hex_value(hex_q), .dot_mask(dot_q), .frame(seg_frame));

	//////////////////////////////////////////////////////////////////////
	// Segment chain
	//////////////////////////////////////////////////////////////////////

	shift_port_if #(.WIDTH(`SEG_FRAME_BITS + 1)) seg_sp ();  // Extra bit for guard

	p2s_serializer #(.DATA_BITS(`SEG_FRAME_BITS)) u_seg_p2s (
		.clk(clk), .reset(reset), .start(seg_start), .pdata(seg_frame),
		.sout(seg_sout), .sclk(seg_sclk), .latch(seg_latch), .done(seg_done),
		.sp(seg_sp.ctrl)
	);

	universal_shifter #(.WIDTH(`SEG_FRAME_BITS + 1)) u_seg_shift (
		.clk(clk), .reset(reset), .port(seg_sp.sreg)
	);

	//////////////////////////////////////////////////////////////////////
	// LED chain
	//////////////////////////////////////////////////////////////////////

	shift_port_if #(.WIDTH(`LED_FRAME_BITS + 1)) led_sp ();

	p2s_serializer #(.DATA_BITS(`LED_FRAME_BITS)) u_led_p2s (
		.clk(clk), .reset(reset), .start(led_start), .pdata(led_q),
		.sout(led_sout), .sclk(led_sclk), .latch(led_latch), .done(led_done),
		.sp(led_sp.ctrl)
	);

	universal_shifter #(.WIDTH(`LED_FRAME_BITS + 1)) u_led_shift (
		.clk(clk), .reset(reset), .port(led_sp.sreg)
	);

endmodule

// ==== bench/tb_serial_display.sv ====
`timescale 1ns/1ps

`include "disp_settings.svh"

module tb_serial_display import disp_types_pkg::*; ();

	localparam int busy_timeout = 1000;   // Far longer than one full transfer

	// Segment patterns from digit F down to digit 0 with segment a in bit 0
	localparam logic [127:0] seg_table = {
		8'h71, 8'h79, 8'h5E, 8'h39, 8'h7C, 8'h77, 8'h6F, 8'h7F,
		8'h07, 8'h7D, 8'h6D, 8'h66, 8'h4F, 8'h5B, 8'h06, 8'h3F
	};

	logic                    clk;
	logic                    reset;
	logic                    update;
	hex_word_t               hex_value;
	logic [`DISP_DIGITS-1:0] dot_mask;
	led_frame_t              led_pattern;
	logic                    busy;
	logic                    seg_sout;
	logic                    seg_sclk;
	logic                    seg_latch;
	logic                    led_sout;
	logic                    led_sclk;
	logic                    led_latch;

	int          cyc;           // Free-running cycle count
	int          test_errors;   // Errors in the running test
	int          errors;
	int          tests_run;
	int          tests_failed;
	logic [31:0] lfsr;

	// Serial capture state for each chain
	seg_frame_t seg_word;
	int         seg_pulses;
	logic       seg_prev;
	led_frame_t led_word;
	int         led_pulses;
	logic       led_prev;
	seg_frame_t seg_words[$];
	int         seg_counts[$];
	int         seg_latch_cyc[$];
	led_frame_t led_words[$];
	int         led_counts[$];
	int         led_latch_cyc[$];

	serial_display_top DUT (
		.clk(clk), .reset(reset), .update(update),
		.hex_value(hex_value), .dot_mask(dot_mask), .led_pattern(led_pattern),
		.busy(busy),
		.seg_sout(seg_sout), .seg_sclk(seg_sclk), .seg_latch(seg_latch),
		.led_sout(led_sout), .led_sclk(led_sclk), .led_latch(led_latch)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;  // 8 ns period
	end

	always @(posedge clk) cyc <= cyc + 1;

	//////////////////////////////////////////////////////////////////////
	// Serial capture sampled mid-cycle where the pins are settled
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		if (reset) begin
			seg_prev   = 1'b0;
			seg_pulses = 0;
			seg_word   = '0;
			led_prev   = 1'b0;
			led_pulses = 0;
			led_word   = '0;
		end else begin
			if (seg_sclk && !seg_prev) begin  // Chip shifts on the rising sclk
				seg_word   = {seg_word[`SEG_FRAME_BITS-2:0], seg_sout};
				seg_pulses = seg_pulses + 1;
			end else if (seg_latch) begin
				seg_words.push_back(seg_word);
				seg_counts.push_back(seg_pulses);
				seg_latch_cyc.push_back(cyc);
				seg_pulses = 0;
				seg_word   = '0;
			end
			if (led_sclk && !led_prev) begin
				led_word   = {led_word[`LED_FRAME_BITS-2:0], led_sout};
				led_pulses = led_pulses + 1;
			end else if (led_latch) begin
				led_words.push_back(led_word);
				led_counts.push_back(led_pulses);
				led_latch_cyc.push_back(cyc);
				led_pulses = 0;
				led_word   = '0;
			end
			seg_prev = seg_sclk;
			led_prev = led_sclk;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Reference model and stimulus helpers
	//////////////////////////////////////////////////////////////////////

	// Digit 7 lands in the top byte with its dot in bit 7
	function automatic seg_frame_t expected_seg_frame(input hex_word_t value,
			input logic [`DISP_DIGITS-1:0] mask);
		seg_frame_t f;
		int         idx;
		f = '0;
		for (int d = 0; d < `DISP_DIGITS; d++) begin
			idx = {28'b0, value[d*4 +: 4]};
			f[d*8 +: 8] = {mask[d], seg_table[idx*8 +: 7]};
		end
		return f;
	endfunction

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			val  = {val[30:0], lfsr[31]};  // One step per bit
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] expected);
		if (got !== expected) begin
			$display("** Error %s: got 0x%0h, expected 0x%0h", name, got, expected);
			test_errors++;
		end
	endtask

	task automatic drive_update(input hex_word_t value, input logic [7:0] mask,
			input led_frame_t pattern);
		@(posedge clk);
		#1;
		hex_value   = value;
		dot_mask    = mask;
		led_pattern = pattern;
		update      = 1'b1;
		@(posedge clk);
		#1;
		update = 1'b0;
	endtask

	task automatic wait_busy(input logic level, output int at_cyc);
		int n;
		n = 0;
		@(negedge clk);
		while (busy !== level && n < busy_timeout) begin
			@(negedge clk);
			n++;
		end
		at_cyc = cyc;
		if (busy !== level) begin
			$display("timeout: busy did not go to %0d within %0d cycles", level,
				busy_timeout);
			test_errors++;
		end
	endtask

	// No chain activity at all
	task automatic check_quiet(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(negedge clk);
			if (busy || seg_sclk || led_sclk || seg_latch || led_latch
					|| seg_sout || led_sout) begin
				$display("display chain active while idle at cycle %0d", cyc);
				test_errors++;
			end
		end
	endtask

	// One update and the full frame pair
	// A positive glitch_at adds a stray update while busy
	task automatic run_transfer(input hex_word_t value, input logic [7:0] mask,
			input led_frame_t pattern, input int glitch_at);
		int fall_cyc;
		int rise_cyc;
		seg_words.delete();
		seg_counts.delete();
		seg_latch_cyc.delete();
		led_words.delete();
		led_counts.delete();
		led_latch_cyc.delete();
		drive_update(value, mask, pattern);
		wait_busy(1'b1, rise_cyc);
		if (glitch_at > 0) begin
			repeat (glitch_at) @(posedge clk);
			drive_update(~value, ~mask, ~pattern);  // Must be dropped
		end
		wait_busy(1'b0, fall_cyc);
		if (seg_words.size() != 1 || led_words.size() != 1) begin
			$display("expected one frame per chain, saw %0d segment and %0d LED",
				seg_words.size(), led_words.size());
			test_errors++;
		end else begin
			check_value("seg_frame", seg_words[0], expected_seg_frame(value, mask));
			check_value("led_frame", {48'b0, led_words[0]}, {48'b0, pattern});
			check_value("seg_sclk_pulses", seg_counts[0], `SEG_FRAME_BITS);
			check_value("led_sclk_pulses", led_counts[0], `LED_FRAME_BITS);
			if (!(rise_cyc < seg_latch_cyc[0] && seg_latch_cyc[0] < led_latch_cyc[0]
					&& led_latch_cyc[0] < fall_cyc)) begin
				$display("latch order wrong: busy high %0d, seg latch %0d, %s %0d, %s %0d",
					rise_cyc, seg_latch_cyc[0], "led latch", led_latch_cyc[0],
					"busy low", fall_cyc);
				test_errors++;
			end
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errors == 0) begin
			$display("test %0d %s: passed", tests_run, name);
		end else begin
			$display("test %0d %s: failed with %0d errors", tests_run, name, test_errors);
			tests_failed++;
		end
		errors      = errors + test_errors;
		test_errors = 0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] r_val;
		logic [31:0] r_mask;
		logic [31:0] r_pat;
		reset        = 1'b1;
		update       = 1'b0;
		hex_value    = '0;
		dot_mask     = '0;
		led_pattern  = '0;
		lfsr         = 32'h903f0254;
		test_errors  = 0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;

		check_quiet(20);
		finish_test("idle after reset");

		run_transfer(32'h01234567, 8'h00, 16'h0000, 0);
		run_transfer(32'h89ABCDEF, 8'h00, 16'h0000, 0);
		finish_test("fixed values");

		for (int t = 0; t < 30; t++) begin
			rand_bits(32, r_val);
			rand_bits(8, r_mask);
			rand_bits(16, r_pat);
			run_transfer(r_val, r_mask[7:0], r_pat[15:0], 0);
		end
		finish_test("random updates");

		run_transfer(32'hFFFF0000, 8'hFF, 16'h8001, 0);  // Edge bits set at both ends
		finish_test("frame timing");

		rand_bits(32, r_val);
		rand_bits(8, r_mask);
		rand_bits(16, r_pat);
		run_transfer(r_val, r_mask[7:0], r_pat[15:0], 40);  // Mid segment frame
		check_quiet(300);                                    // No second transfer
		finish_test("update while busy");

		$display("%0d tests run, %0d passed, %0d failed, %0d errors",
			tests_run, tests_run - tests_failed, tests_failed, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+common
common/disp_types_pkg.sv
common/disp_ctrl_pkg.sv
common/shift_port_if.sv
serializer/universal_shifter.sv
serializer/p2s_serializer.sv
hdl/seg_encoder.sv
hdl/display_ctrl.sv
hdl/serial_display_top.sv
bench/tb_serial_display.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = tb_serial_display
FILELIST  = list.f
LOG       = sim.log
PASS_MSG  = ALL TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
